// File: hw/cache_pkg.sv
package cache_pkg;

	// One data word, shared by APB and SDRAM
	typedef logic [31:0] word_t;

	// SDRAM word address, not a byte address
	typedef logic [24:0] sdram_addr_t;

	// Burst length in words
	typedef logic [7:0] burst_len_t;

	// Cache control
	typedef enum logic [1:0] {
		IDLE,      // Waiting for an APB request
		LOOKUP,    // Tag compare on the latched address
		FILL_WAIT, // Miss outstanding at the handler
		RESPOND    // One cycle of resp_valid
	} cache_state_t;

	// Miss handler control
	typedef enum logic [1:0] {
		MH_IDLE,    // Free for a new miss
		MH_ISSUE,   // Counter cleared, burst request raised
		MH_COLLECT, // Beats land in the line register
		MH_HOLD     // Line offered to the cache
	} mh_state_t;

	// Memory side command/data sequencing
	typedef enum logic [1:0] {
		BR_IDLE, // No burst
		BR_CMD,  // Command waiting for mem_cmd_ready
		BR_DATA  // Counting returned words
	} bridge_state_t;

endpackage

// File: hw/cache_ifs.sv
// Cache to miss handler, valid/stall on both directions
interface miss_if #(
	parameter int LINE_W  = 128,
	parameter int TAG_W   = 3,
	parameter int INDEX_W = 4
);
	logic [TAG_W+INDEX_W-1:0] mh_addr;    // Line number, tag above index
	logic                     mh_valid;   // Miss request
	logic                     mh_busy;    // Handler still working on a request
	logic [LINE_W-1:0]        line_data;  // Assembled line, word 0 in the low bits
	logic                     line_valid; // Line offered
	logic                     line_stall; // Cache not ready for a line

	modport cache (
		output mh_addr,
		output mh_valid,
		input  mh_busy,
		input  line_data,
		input  line_valid,
		output line_stall
	);

	modport handler (
		input  mh_addr,
		input  mh_valid,
		output mh_busy,
		output line_data,
		output line_valid,
		input  line_stall
	);
endinterface

// Miss handler to memory read bridge, request/valid/done
interface mem_rd_if;
	import cache_pkg::*;

	sdram_addr_t rd_addr;    // First word of the burst
	burst_len_t  rd_len;     // Words in the burst
	logic        rd_req;     // Held until burst_done
	logic        beat_valid; // One word this cycle
	word_t       beat_data;
	logic        burst_done; // Pulse after the last beat

	modport handler (
		output rd_addr,
		output rd_len,
		output rd_req,
		input  beat_valid,
		input  beat_data,
		input  burst_done
	);

	modport bridge (
		input  rd_addr,
		input  rd_len,
		input  rd_req,
		output beat_valid,
		output beat_data,
		output burst_done
	);
endinterface

// File: hw/apb_read_port.sv
module apb_read_port (
	input  logic             clk,
	input  logic             rst,
	// APB slave
	input  logic             psel,
	input  logic             penable,
	input  logic             pwrite,
	input  cache_pkg::word_t paddr,
	input  cache_pkg::word_t pwdata,
	output cache_pkg::word_t prdata,
	output logic             pready,
	output logic             pslverr,
	// Toward the cache
	output logic             req_valid,
	output logic             req_write,
	output cache_pkg::word_t req_addr,
	input  logic             resp_valid,
	input  cache_pkg::word_t resp_data,
	input  logic             resp_err
);
	import cache_pkg::*;

	logic  pending;  // Request issued, no response yet
	word_t prdata_q; // Last read data, keeps the bus quiet between transfers

	// Request goes out in the setup phase so a write can finish in the first access cycle
	assign req_valid = psel && !penable && !pending;
	assign req_write = pwrite;
	assign req_addr  = paddr;

	// Completion follows the cache response directly
	assign pready  = penable && pending && resp_valid;
	assign pslverr = pready && resp_err; // Only reads report errors
	assign prdata  = pready ? resp_data : prdata_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pending <= 1'b0;
		end else if (req_valid) begin
			pending <= 1'b1;
		end else if (pready) begin
			pending <= 1'b0; // Transfer done
		end
	end

	always_ff @(posedge clk) begin
		if (pready)
			prdata_q <= resp_data;
	end

	// Host keeps the address through wait states, the cache relies on it
	assert property (@(posedge clk) disable iff (rst)
		penable && !pready |=> $stable(paddr));

	// Write data is ignored by the cache but must still be driven by the host
	assert property (@(posedge clk) disable iff (rst)
		psel && penable && pwrite |-> !$isunknown(pwdata));

endmodule

// File: hw/direct_mapped_cache.sv
module direct_mapped_cache #(
	parameter int LINE_W  = 128,
	parameter int TAG_W   = 3,
	parameter int INDEX_W = 4
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             req_valid,
	input  logic             req_write,
	input  cache_pkg::word_t req_addr,
	output logic             resp_valid,
	output cache_pkg::word_t resp_data,
	output logic             resp_err,
	miss_if.cache            mif
);
	import cache_pkg::*;

	localparam int NUM_WORDS = LINE_W / 32;
	localparam int OFF_W     = $clog2(NUM_WORDS);
	localparam int NUM_LINES = 1 << INDEX_W;
	localparam int LO        = OFF_W + 2;            // Lowest index bit
	localparam int ADDR_W    = TAG_W + INDEX_W + LO; // Byte address bits covered

	cache_state_t state, state_n;

	word_t              addr_q;  // Latched request address
	logic               write_q; // Latched request is an invalidate
	logic [OFF_W-1:0]   off;
	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0]   tag;
	logic               out_of_range;
	logic               hit;
	logic               fill_take;

	logic [NUM_LINES-1:0] valid_bits;
	logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
	logic [LINE_W-1:0]    line_mem [NUM_LINES];

	// Field split of the byte address
	assign off          = addr_q[LO-1:2];
	assign index        = addr_q[LO+INDEX_W-1:LO];
	assign tag          = addr_q[ADDR_W-1:LO+INDEX_W];
	assign out_of_range = |addr_q[31:ADDR_W]; // Upper bits must be zero
	assign hit          = valid_bits[index] && (tag_mem[index] == tag);
	assign fill_take    = mif.line_valid && !mif.line_stall;

	// Miss request, held for the whole fill
	assign mif.mh_valid   = (state == FILL_WAIT);
	assign mif.mh_addr    = {tag, index};
	assign mif.line_stall = (state != FILL_WAIT);
	assign resp_valid     = (state == RESPOND);

	always_comb begin
		state_n = state;
		unique case (state)
			IDLE:      if (req_valid) state_n = req_write ? RESPOND : LOOKUP;
			LOOKUP:    state_n = (out_of_range || hit) ? RESPOND : FILL_WAIT;
			FILL_WAIT: if (fill_take) state_n = RESPOND;
			RESPOND:   state_n = IDLE;
			default:   state_n = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= IDLE;
			write_q <= 1'b0;
		end else begin
			state <= state_n;
			if (state == IDLE && req_valid)
				write_q <= req_write;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req_valid)
			addr_q <= req_addr;
	end

	// Valid bits set on refill, cleared when an invalidate completes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_bits <= '0;
		end else if (fill_take) begin
			valid_bits[index] <= 1'b1;
		end else if (state == RESPOND && write_q) begin
			valid_bits[index] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_take) begin
			tag_mem[index]  <= tag;
			line_mem[index] <= mif.line_data;
		end
	end

	// Response word picked by the word offset
	always_ff @(posedge clk) begin
		if (state == LOOKUP)
			resp_data <= line_mem[index][off*32 +: 32];
		else if (fill_take)
			resp_data <= mif.line_data[off*32 +: 32]; // Straight from the refill
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			resp_err <= 1'b0;
		else if (state != RESPOND && state_n == RESPOND)
			resp_err <= (state == LOOKUP) && out_of_range;
	end

	// A new miss never starts while the handler still holds an older one
	assert property (@(posedge clk) disable iff (rst)
		$rose(mif.mh_valid) |-> !mif.mh_busy);

	// Lines only come back while a fill is pending
	assert property (@(posedge clk) disable iff (rst)
		mif.line_valid |-> state == FILL_WAIT);

endmodule

// File: hw/miss_handler.sv
module miss_handler #(
	parameter int                     LINE_W    = 128,
	parameter int                     TAG_W     = 3,
	parameter int                     INDEX_W   = 4,
	parameter cache_pkg::sdram_addr_t BASE_ADDR = 25'h0100000
) (
	input  logic      clk,
	input  logic      rst,
	miss_if.handler   mif,
	mem_rd_if.handler mrif
);
	import cache_pkg::*;

	localparam int NUM_WORDS = LINE_W / 32;
	localparam int OFF_W     = $clog2(NUM_WORDS);

	mh_state_t state, state_n;

	logic [TAG_W+INDEX_W-1:0]  line_num;   // Tag and index together
	sdram_addr_t               translated; // First SDRAM word of the line
	logic [OFF_W-1:0]          word_cnt;   // Slot for the next beat
	word_t [NUM_WORDS-1:0]     line_q;     // Line being assembled
	logic                      take;       // Request accepted
	logic                      beat;       // Word arriving

	assign line_num   = mif.mh_addr;
	// Power-of-two line, so the multiply is a shift
	assign translated = BASE_ADDR + (sdram_addr_t'(line_num) << OFF_W);

	assign take = (state == MH_IDLE) && mif.mh_valid;
	assign beat = (state == MH_COLLECT) && mrif.beat_valid;

	assign mrif.rd_len = burst_len_t'(NUM_WORDS); // Always one full line
	assign mrif.rd_req = (state == MH_ISSUE) || (state == MH_COLLECT);

	assign mif.line_data  = line_q;
	assign mif.line_valid = (state == MH_HOLD);
	assign mif.mh_busy    = mif.mh_valid && (state != MH_IDLE);

	always_comb begin
		state_n = state;
		unique case (state)
			MH_IDLE:    if (mif.mh_valid) state_n = MH_ISSUE;
			MH_ISSUE:   state_n = MH_COLLECT;
			MH_COLLECT: if (mrif.burst_done) state_n = MH_HOLD; // Line complete
			MH_HOLD:    if (!mif.line_stall) state_n = MH_IDLE;
			default:    state_n = MH_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			state <= MH_IDLE;
		else
			state <= state_n;
	end

	// Address register, loaded on a request and stepped per beat
	always_ff @(posedge clk) begin
		if (take)
			mrif.rd_addr <= translated;
		else if (beat)
			mrif.rd_addr <= mrif.rd_addr + 1'b1;
	end

	// Word counter
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt <= '0;
		end else if (state == MH_ISSUE) begin
			word_cnt <= '0;
		end else if (beat) begin
			word_cnt <= word_cnt + 1'b1; // Wraps after the last word
		end
	end

	// Beats steered into the line, address order
	always_ff @(posedge clk) begin
		if (beat)
			line_q[word_cnt] <= mrif.beat_data;
	end

	// Bridge only forwards words of a burst this block asked for
	assert property (@(posedge clk) disable iff (rst)
		mrif.beat_valid |-> state == MH_COLLECT);

endmodule

// File: hw/mem_read_bridge.sv
module mem_read_bridge #(
	parameter int LINE_W = 128
) (
	input  logic                   clk,
	input  logic                   rst,
	mem_rd_if.bridge               mrif,
	output logic                   mem_cmd_valid,
	input  logic                   mem_cmd_ready,
	output cache_pkg::sdram_addr_t mem_cmd_addr,
	output cache_pkg::burst_len_t  mem_cmd_len,
	input  logic                   mem_rdata_valid,
	input  cache_pkg::word_t       mem_rdata
);
	import cache_pkg::*;

	localparam int NUM_WORDS = LINE_W / 32;
	localparam int CNT_W     = $clog2(NUM_WORDS + 1); // Holds a full line count

	bridge_state_t state, state_n;

	logic [CNT_W-1:0] beat_cnt;  // Words seen in this burst
	logic             last_beat;

	assign mem_cmd_valid   = (state == BR_CMD);
	assign mrif.beat_valid = (state == BR_DATA) && mem_rdata_valid;
	assign mrif.beat_data  = mem_rdata;
	assign last_beat       = mrif.beat_valid
		&& (burst_len_t'(beat_cnt + 1'b1) == mem_cmd_len);

	always_comb begin
		state_n = state;
		unique case (state)
			// burst_done still high means rd_req is about to drop
			BR_IDLE: if (mrif.rd_req && !mrif.burst_done) state_n = BR_CMD;
			BR_CMD:  if (mem_cmd_ready) state_n = BR_DATA;
			BR_DATA: if (last_beat) state_n = BR_IDLE;
			default: state_n = BR_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state           <= BR_IDLE;
			beat_cnt        <= '0;
			mrif.burst_done <= 1'b0;
		end else begin
			state           <= state_n;
			mrif.burst_done <= last_beat; // One cycle after the last word
			if (state == BR_CMD)
				beat_cnt <= '0;
			else if (mrif.beat_valid)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// Command fields captured once, stable while waiting for ready
	always_ff @(posedge clk) begin
		if (state == BR_IDLE && state_n == BR_CMD) begin
			mem_cmd_addr <= mrif.rd_addr;
			mem_cmd_len  <= mrif.rd_len;
		end
	end

	// Memory never returns data without a command
	assert property (@(posedge clk) disable iff (rst)
		!(mem_rdata_valid && state == BR_IDLE));

endmodule

// File: hw/cache_fill_top.sv
module cache_fill_top #(
	parameter int                     LINE_W    = 128,
	parameter int                     TAG_W     = 3,
	parameter int                     INDEX_W   = 4,
	parameter cache_pkg::sdram_addr_t BASE_ADDR = 25'h0100000
) (
	input  logic                   clk,
	input  logic                   rst,
	// Host APB
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  cache_pkg::word_t       paddr,
	input  cache_pkg::word_t       pwdata,
	output cache_pkg::word_t       prdata,
	output logic                   pready,
	output logic                   pslverr,
	// SDRAM burst read
	output logic                   mem_cmd_valid,
	input  logic                   mem_cmd_ready,
	output cache_pkg::sdram_addr_t mem_cmd_addr,
	output cache_pkg::burst_len_t  mem_cmd_len,
	input  logic                   mem_rdata_valid,
	input  cache_pkg::word_t       mem_rdata
);
	import cache_pkg::*;

	logic  req_valid, req_write;
	word_t req_addr;
	logic  resp_valid, resp_err;
	word_t resp_data;

	miss_if #(.LINE_W(LINE_W), .TAG_W(TAG_W), .INDEX_W(INDEX_W)) mh_bus ();
	mem_rd_if rd_bus ();

	apb_read_port apb_read_port_inst (
		.clk, .rst,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.req_valid, .req_write, .req_addr,
		.resp_valid, .resp_data, .resp_err
	);

	direct_mapped_cache #(.LINE_W(LINE_W), .TAG_W(TAG_W), .INDEX_W(INDEX_W))
	direct_mapped_cache_inst (
		.clk, .rst,
		.req_valid, .req_write, .req_addr,
		.resp_valid, .resp_data, .resp_err,
		.mif(mh_bus.cache)
	);

	miss_handler #(.LINE_W(LINE_W), .TAG_W(TAG_W), .INDEX_W(INDEX_W), .BASE_ADDR(BASE_ADDR))
	miss_handler_inst (
		.clk, .rst,
		.mif(mh_bus.handler),
		.mrif(rd_bus.handler)
	);

	mem_read_bridge #(.LINE_W(LINE_W)) mem_read_bridge_inst (
		.clk, .rst,
		.mrif(rd_bus.bridge),
		.mem_cmd_valid, .mem_cmd_ready, .mem_cmd_addr, .mem_cmd_len,
		.mem_rdata_valid, .mem_rdata
	);

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int HALF_PERIOD = 4, // Period of 8
	parameter int RST_CYCLES  = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0; // Released away from the active edge
	end

	always #HALF_PERIOD clk = ~clk;

endmodule

// File: testbench/cache_fill_tb.sv
module cache_fill_tb;
	import cache_pkg::*;

	localparam sdram_addr_t BASE_ADDR  = 25'h0100000;
	localparam int          WORDS      = 4;    // Words per 128-bit line
	localparam int          MAX_CYCLES = 4000; // About four times the longest run

	logic        clk, rst;
	logic        psel, penable, pwrite;
	word_t       paddr, pwdata, prdata;
	logic        pready, pslverr;
	logic        mem_cmd_valid, mem_cmd_ready;
	sdram_addr_t mem_cmd_addr;
	burst_len_t  mem_cmd_len;
	logic        mem_rdata_valid;
	word_t       mem_rdata;

	logic [31:0] lcg_state = 32'he8c804e0;
	logic        ref_valid [16]; // Lines filled and not evicted since
	logic [2:0]  ref_tag   [16];
	word_t       exp_data;
	logic        exp_err;
	logic        exp_hit;
	sdram_addr_t exp_cmd_addr;
	int          exp_cmd_count   = 0;
	int          cmd_count       = 0; // Accepted memory commands
	int          cycle_count     = 0;
	int          error_count     = 0;
	int          errors_at_start = 0;
	int          test_num        = 0;
	int          tests_bad       = 0;
	logic        access_seen     = 1'b0;
	logic        xfer_done       = 1'b0; // APB transfer ended last edge

	tb_clock_gen clock_gen_inst (.clk, .rst);

	cache_fill_top cache_fill_top_inst (
		.clk, .rst,
		.psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
		.mem_cmd_valid, .mem_cmd_ready, .mem_cmd_addr, .mem_cmd_len,
		.mem_rdata_valid, .mem_rdata
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Content of SDRAM word A
	function automatic word_t model_word(input sdram_addr_t a);
		return word_t'(a) ^ 32'hC0DE0000;
	endfunction

	// Tag [10:8], index [7:4], word offset [3:2]
	function automatic word_t line_addr(input int tg, input int idx, input int off);
		return word_t'((tg << 8) | (idx << 4) | (off << 2));
	endfunction

	task report_failure(input string msg);
		$display("FAILED at time %0t: %s", $time, msg);
		error_count++;
	endtask

	// One APB transfer, setup then access until pready
	task automatic apb_transfer(input word_t addr, input logic write);
		@(negedge clk);
		psel        = 1'b1;
		penable     = 1'b0;
		pwrite      = write;
		paddr       = addr;
		pwdata      = write ? next_rand() : '0;
		access_seen = 1'b1;
		@(negedge clk);
		penable = 1'b1;
		do @(negedge clk); while (!xfer_done);
		psel    = 1'b0; // One idle cycle follows
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_word(input word_t addr);
		logic [6:0] line;
		logic [3:0] idx;
		logic [2:0] tg;
		logic [1:0] off;
		line = addr[10:4];
		idx  = addr[7:4];
		tg   = addr[10:8];
		off  = addr[3:2];
		exp_err      = |addr[31:11]; // Beyond the 2 KiB cached range
		exp_hit      = !exp_err && ref_valid[idx] && (ref_tag[idx] == tg);
		exp_cmd_addr = BASE_ADDR + sdram_addr_t'(line) * WORDS;
		exp_data     = model_word(exp_cmd_addr + off);
		if (!exp_err && !exp_hit) begin
			exp_cmd_count++; // Exactly one burst per miss
			ref_valid[idx] = 1'b1;
			ref_tag[idx]   = tg;
		end
		apb_transfer(addr, 1'b0);
	endtask

	task automatic invalidate_line(input word_t addr);
		ref_valid[addr[7:4]] = 1'b0; // Whole index, tag ignored
		apb_transfer(addr, 1'b1);
	endtask

	task end_test(input string name);
		repeat (3) @(negedge clk); // Let multi-cycle checks finish
		test_num++;
		if (error_count != errors_at_start)
			tests_bad++;
		$display("Test %0d %s: %s", test_num, name,
			(error_count == errors_at_start) ? "ok" : "check failures");
		errors_at_start = error_count;
	endtask

	always @(posedge clk) begin
		xfer_done <= psel && penable && pready;
		if (mem_cmd_valid && mem_cmd_ready)
			cmd_count <= cmd_count + 1;
	end

	// SDRAM model, random ready delay and word gaps of 0 to 3 cycles
	initial begin : memory_model
		sdram_addr_t base;
		int          len;
		int          gap;
		mem_cmd_ready   = 1'b0;
		mem_rdata_valid = 1'b0;
		mem_rdata       = '0;
		forever begin
			@(negedge clk);
			if (mem_cmd_valid) begin
				base = mem_cmd_addr;
				len  = mem_cmd_len;
				gap  = (next_rand() >> 16) % 4;
				repeat (gap) @(negedge clk);
				mem_cmd_ready = 1'b1;
				@(negedge clk); // Accepted at the edge in between
				mem_cmd_ready = 1'b0;
				for (int k = 0; k < len; k++) begin
					gap = (next_rand() >> 16) % 4;
					repeat (gap) @(negedge clk);
					mem_rdata_valid = 1'b1;
					mem_rdata       = model_word(base + k); // Address order
					@(negedge clk);
					mem_rdata_valid = 1'b0;
				end
			end
		end
	end

	reset_quiet: assert property (@(posedge clk) disable iff (rst)
		!access_seen |-> !pready && !pslverr && !mem_cmd_valid)
		else report_failure("bus outputs active before the first APB access");

	read_value: assert property (@(posedge clk) disable iff (rst)
		psel && penable && pready && !pwrite |->
			(pslverr == exp_err) && (exp_err || prdata == exp_data))
		else report_failure($sformatf("read data or pslverr wrong, expected data %h err %b",
			exp_data, exp_err));

	hit_latency: assert property (@(posedge clk) disable iff (rst)
		psel && !penable && !pwrite && exp_hit |=> !pready ##1 pready)
		else report_failure("read hit did not complete in the second access cycle");

	write_latency: assert property (@(posedge clk) disable iff (rst)
		psel && !penable && pwrite |=> pready)
		else report_failure("write did not complete in the first access cycle");

	cmd_fields: assert property (@(posedge clk) disable iff (rst)
		mem_cmd_valid && mem_cmd_ready |->
			(mem_cmd_addr == exp_cmd_addr) && (mem_cmd_len == burst_len_t'(WORDS)))
		else report_failure($sformatf("burst command wrong, expected addr %h len %0d",
			exp_cmd_addr, WORDS));

	cmd_total: assert property (@(posedge clk) disable iff (rst)
		psel && penable && pready |-> cmd_count == exp_cmd_count)
		else report_failure($sformatf("memory command count wrong, expected %0d",
			exp_cmd_count));

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin : stimulus
		word_t r;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		exp_err = 1'b0;
		exp_hit = 1'b0;
		for (int k = 0; k < 16; k++) begin
			ref_valid[k] = 1'b0;
			ref_tag[k]   = '0;
		end
		@(negedge rst);
		end_test("reset quiet");

		read_word(line_addr(1, 2, 1)); // Cold miss
		end_test("read miss");

		read_word(line_addr(1, 2, 0));
		read_word(line_addr(1, 2, 2));
		read_word(line_addr(1, 2, 3));
		end_test("hits in filled line");

		read_word(line_addr(5, 2, 0)); // Evicts tag 1
		read_word(line_addr(1, 2, 3));
		end_test("tag conflict");

		invalidate_line(line_addr(1, 2, 0));
		read_word(line_addr(1, 2, 2));
		read_word(32'h0000_0800); // First address past the range
		end_test("invalidate and range error");

		// Four indexes and eight tags, a mix of hits and evictions
		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			read_word(line_addr(r[18:16], r[21:20], r[25:24]));
		end
		end_test("random reads");

		$display("Summary: %0d tests, %0d with failed checks, %0d failed checks, %0d bursts",
			test_num, tests_bad, error_count, cmd_count);
		if (error_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// File: tb.f
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/apb_read_port.sv
hw/direct_mapped_cache.sv
hw/miss_handler.sv
hw/mem_read_bridge.sv
hw/cache_fill_top.sv
testbench/tb_clock_gen.sv
testbench/cache_fill_tb.sv
